/* source/trs_io_pkg.sv */
`default_nettype none

package trs_io_pkg;

  localparam logic [7:0] COOKIE       = 8'haf;
  localparam logic [7:0] VERSION_BYTE = {3'd0, 5'd3}; // major 0, minor 3
  localparam logic [5:0] REQ_PULSE    = 6'd50;        // req length in clk cycles
  localparam int         RAM_AW       = 15;           // 32 KB
  localparam logic [7:0] TRS_IO_PORT  = 8'h1f;
  localparam logic [3:0] FREHD_NIBBLE = 4'hc;         // ports c0h-cfh
  localparam int         MAX_PARAMS   = 3;

  // spi command opcodes, values shared with the microcontroller firmware
  typedef enum logic [7:0] {
    get_cookie  = 8'd0,
    bram_poke   = 8'd1,
    bram_peek   = 8'd2,
    dbus_read   = 8'd3,
    dbus_write  = 8'd4,
    data_ready  = 8'd5,
    get_version = 8'd15,
    abus_read   = 8'd18,
    set_led     = 8'd26,
    get_config  = 8'd27
  } cmd_op_e;

  typedef enum logic [1:0] {
    idle,
    read_params,
    wait_mem,
    send_reply
  } seq_state_e;

  // service code shown to the microcontroller on esp_s
  typedef enum logic [3:0] {
    trs_io_in  = 4'd0,
    trs_io_out = 4'd1,
    frehd_in   = 4'd2,
    frehd_out  = 4'd3,
    none       = 4'd15
  } esp_code_e;

  typedef struct packed {
    cmd_op_e                    op;
    logic [MAX_PARAMS-1:0][7:0] params;
  } cmd_action_t;

  typedef struct packed {
    logic      ram_rd;
    logic      ram_wr;
    logic      esp_in;
    logic      esp_out;
    logic      trs_io_hit;  // port 1fh, either direction
    esp_code_e esp_code;
  } trs_sel_t;

  typedef struct packed {
    logic              en;
    logic              we;
    logic [RAM_AW-1:0] addr;
    logic [7:0]        data;
  } ram_req_t;

endpackage

`default_nettype wire

/* source/spi_byte_link.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_link (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] reply_byte,
  input  logic       reply_valid,
  output logic       reply_ready
);

  logic [2:0] sck_q;  // extra stage for edge detect
  logic [1:0] cs_q;
  logic [1:0] mosi_q;
  logic       cs_active;
  logic       sck_rise;
  logic       sck_fall;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [3:0] tx_left;
  logic       tx_active; // reply byte in flight, inbound byte is a dummy

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_q  <= '0;
      cs_q   <= 2'b11;
      mosi_q <= '0;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  assign cs_active = ~cs_q[1];
  assign sck_rise  = sck_q[2:1] == 2'b01;
  assign sck_fall  = sck_q[2:1] == 2'b10;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active & sck_rise & (bit_cnt == 3'd7) & ~tx_active;
      if (!cs_active)
        bit_cnt <= '0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_q[1]}; // msb first
  end

  assign rx_byte = rx_shift;

  // accept a reply only between bytes with nothing left to send
  assign reply_ready = cs_active & ~tx_active & (tx_left == 4'd0) & (bit_cnt == 3'd0);

  always_ff @(posedge clk) begin
    if (!rst_n || !cs_active) begin
      tx_left   <= '0;
      tx_active <= 1'b0;
      miso      <= 1'b0;
    end else if (reply_valid && reply_ready) begin
      tx_left   <= 4'd8;
      tx_active <= 1'b1;
    end else begin
      if (sck_fall) begin
        miso <= (tx_left != 4'd0) & tx_shift[7]; // back to 0 once drained
        if (tx_left != 4'd0)
          tx_left <= tx_left - 4'd1;
      end
      if (sck_rise && bit_cnt == 3'd7)
        tx_active <= 1'b0; // dummy byte complete
    end
  end

  always_ff @(posedge clk) begin
    if (reply_valid && reply_ready)
      tx_shift <= reply_byte;
    else if (sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

endmodule

`default_nettype wire

/* source/cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  rx_byte,
  input  logic        rx_valid,
  output logic [7:0]  reply_byte,
  output logic        reply_valid,
  input  logic        reply_ready,
  output ram_req_t    mem_req,
  input  logic [7:0]  mem_rdata,
  input  logic [15:0] bus_addr,
  input  logic [7:0]  bus_data,
  input  logic [3:0]  conf,
  input  logic        trs_io_access,
  output logic [7:0]  dbus_latch,
  output logic        int_req,
  output logic [2:0]  led
);

  seq_state_e  state;
  cmd_action_t act;
  logic [1:0]  params_left;
  logic [1:0]  idx;
  logic [7:0]  reply_q;
  logic        ready_flag;  // set by data_ready, cleared by host access to 1fh
  logic        last_param;
  logic [7:0]  addr_hi;

  function automatic logic [1:0] param_count(input logic [7:0] op);
    case (op)
      bram_poke:           return 2'd3; // addr lo, addr hi, data
      bram_peek:           return 2'd2; // addr lo, addr hi
      dbus_write, set_led: return 2'd1;
      default:             return 2'd0;
    endcase
  endfunction

  assign last_param = (state == read_params) & rx_valid & (params_left == 2'd1);

  // for a peek the high address byte is the one arriving now
  assign addr_hi = (act.op == bram_peek) ? rx_byte : act.params[1];

  always_comb begin
    mem_req      = '0;
    mem_req.addr = {addr_hi[6:0], act.params[0]};
    mem_req.data = rx_byte;
    if (last_param && (act.op == bram_poke || act.op == bram_peek)) begin
      mem_req.en = 1'b1;
      mem_req.we = act.op == bram_poke;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= idle;
      params_left <= '0;
      idx         <= '0;
      ready_flag  <= 1'b0;
      led         <= '0;
    end else begin
      if (trs_io_access)
        ready_flag <= 1'b0;
      case (state)
        idle: if (rx_valid) begin
          idx         <= '0;
          params_left <= param_count(rx_byte);
          case (rx_byte)
            get_cookie, get_version, get_config, abus_read, dbus_read:
              state <= send_reply;
            bram_poke, bram_peek, dbus_write, set_led:
              state <= read_params;
            data_ready:
              ready_flag <= 1'b1;
            default: state <= idle; // unknown opcode dropped
          endcase
        end
        read_params: if (rx_valid) begin
          idx         <= idx + 2'd1;
          params_left <= params_left - 2'd1;
          if (last_param) begin
            if (act.op == bram_peek)
              state <= wait_mem;
            else
              state <= idle;
            if (act.op == set_led)
              led <= rx_byte[2:0];
          end
        end
        wait_mem:   state <= send_reply; // ram read in flight
        send_reply: if (reply_ready) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle && rx_valid) begin
      act.op <= cmd_op_e'(rx_byte);
      case (rx_byte)
        get_cookie:  reply_q <= COOKIE;
        get_version: reply_q <= VERSION_BYTE;
        get_config:  reply_q <= {4'd0, conf};
        abus_read:   reply_q <= bus_addr[7:0];
        dbus_read:   reply_q <= bus_data;
        default:     reply_q <= reply_q;
      endcase
    end
    if (state == read_params && rx_valid)
      act.params[idx] <= rx_byte;
    if (last_param && act.op == dbus_write)
      dbus_latch <= rx_byte;
    if (state == wait_mem)
      reply_q <= mem_rdata;
  end

  assign reply_valid = state == send_reply;
  assign reply_byte  = reply_q;
  assign int_req     = ~conf[3] & ready_flag; // model iii only

endmodule

`default_nettype wire

/* source/trs_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_bus_port
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        ioreq_n,
  input  logic [3:0]  conf,
  output trs_sel_t    sel,
  output logic        access_edge,
  output logic        trs_io_access,
  output logic [15:0] bus_addr,
  output logic [7:0]  bus_data,
  input  logic [7:0]  host_rdata,
  input  logic [7:0]  dbus_latch,
  output logic [7:0]  d_out,
  output logic        d_oe
);

  logic       is_m3;
  logic [3:0] stb_raw;  // {rd, wr, in, out}, active high
  logic [3:0] stb_s1;
  logic [3:0] stb_s2;
  logic       active_d;
  logic       rd_s, wr_s, in_s, out_s;
  logic       ram_hit;
  logic       port_1f;
  logic       port_cx;

  // model iii has no shared ram and qualifies io strobes with ioreq_n
  assign stb_raw[3] = ~is_m3 & ~rd_n;
  assign stb_raw[2] = ~is_m3 & ~wr_n;
  assign stb_raw[1] = ~in_n  & ~(is_m3 & ioreq_n);
  assign stb_raw[0] = ~out_n & ~(is_m3 & ioreq_n);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_m3    <= 1'b0;
      stb_s1   <= '0;
      stb_s2   <= '0;
      active_d <= 1'b0;
    end else begin
      is_m3    <= ~conf[3];
      stb_s1   <= stb_raw;
      stb_s2   <= stb_s1;
      active_d <= |stb_s2;
    end
  end

  // sampled bus for abus_read and dbus_read
  always_ff @(posedge clk) begin
    bus_addr <= a;
    bus_data <= d_in;
  end

  assign {rd_s, wr_s, in_s, out_s} = stb_s2;
  assign access_edge = (|stb_s2) & ~active_d;

  assign ram_hit = ~is_m3 & a[15];                // 8000h-ffffh
  assign port_1f = a[7:0] == TRS_IO_PORT;
  assign port_cx = a[7:4] == FREHD_NIBBLE;

  always_comb begin
    sel.ram_rd     = ram_hit & rd_s;
    sel.ram_wr     = ram_hit & wr_s;
    sel.esp_in     = (port_1f | port_cx) & in_s;
    sel.esp_out    = (port_1f | port_cx) & out_s;
    sel.trs_io_hit = port_1f & (in_s | out_s);
    if (port_1f && in_s)
      sel.esp_code = trs_io_in;
    else if (port_1f && out_s)
      sel.esp_code = trs_io_out;
    else if (port_cx && in_s)
      sel.esp_code = frehd_in;
    else if (port_cx && out_s)
      sel.esp_code = frehd_out;
    else
      sel.esp_code = none;
  end

  assign trs_io_access = access_edge & sel.trs_io_hit;

  assign d_oe  = sel.ram_rd | sel.esp_in;
  assign d_out = sel.ram_rd ? host_rdata : dbus_latch;

endmodule

`default_nettype wire

/* source/esp_wait_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module esp_wait_ctrl
  import trs_io_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  trs_sel_t  sel,
  input  logic      access_edge,
  input  logic      done,
  output logic      req,
  output logic      wait_req,
  output esp_code_e esp_s
);

  logic [2:0] done_q;
  logic [5:0] req_cnt;
  logic       esp_access;
  logic       esp_edge;
  logic       done_rise;

  assign esp_access = sel.esp_in | sel.esp_out;
  assign esp_edge   = access_edge & esp_access;
  assign done_rise  = done_q[1] & ~done_q[2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done_q   <= '0;
      req_cnt  <= '0;
      wait_req <= 1'b0;
    end else begin
      done_q <= {done_q[1:0], done};
      if (esp_edge)
        req_cnt <= REQ_PULSE;
      else if (req_cnt != 6'd0)
        req_cnt <= req_cnt - 6'd1;
      // a new access wins over a late done
      if (esp_edge)
        wait_req <= 1'b1;
      else if (done_rise)
        wait_req <= 1'b0;
    end
  end

  assign req   = req_cnt != 6'd0;
  assign esp_s = esp_access ? sel.esp_code : none;

endmodule

`default_nettype wire

/* source/shared_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module shared_ram
  import trs_io_pkg::*;
(
  input  logic              clk,
  input  trs_sel_t          sel,
  input  logic              access_edge,
  input  logic [RAM_AW-1:0] a_addr,
  input  logic [7:0]        d_in,
  output logic [7:0]        host_rdata,
  input  ram_req_t          mem_req,
  output logic [7:0]        mem_rdata
);

  logic [7:0]        mem [0:(1 << RAM_AW) - 1];
  logic [RAM_AW-1:0] host_addr_q;
  logic              host_we;

  assign host_we = access_edge & sel.ram_wr;

  // host port: address latched at the access edge, data one cycle later
  always_ff @(posedge clk) begin
    if (access_edge && sel.ram_rd)
      host_addr_q <= a_addr;
  end

  always_ff @(posedge clk) begin
    if (host_we)
      mem[a_addr] <= d_in;
    if (mem_req.en && mem_req.we)
      mem[mem_req.addr] <= mem_req.data;
    host_rdata <= mem[host_addr_q];
    if (mem_req.en)
      mem_rdata <= mem[mem_req.addr]; // read first on a poke
  end

endmodule

`default_nettype wire

/* source/trs_io_top.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_top
  import trs_io_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] a,
  input  logic [7:0]  d_in,
  output logic [7:0]  d_out,
  output logic        d_oe,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        in_n,
  input  logic        out_n,
  input  logic        ioreq_n,
  input  logic [3:0]  conf,
  input  logic        sck,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output logic        req,
  input  logic        done,
  output logic        wait_req,
  output esp_code_e   esp_s,
  output logic        int_req,
  output logic [2:0]  led
);

  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic [7:0]  reply_byte;
  logic        reply_valid;
  logic        reply_ready;
  ram_req_t    mem_req;
  logic [7:0]  mem_rdata;
  trs_sel_t    sel;
  logic        access_edge;
  logic        trs_io_access;
  logic [15:0] bus_addr;
  logic [7:0]  bus_data;
  logic [7:0]  host_rdata;
  logic [7:0]  dbus_latch;

  spi_byte_link spi_byte_link_inst (
    .clk, .rst_n, .sck, .cs_n, .mosi, .miso,
    .rx_byte, .rx_valid, .reply_byte, .reply_valid, .reply_ready
  );

  cmd_sequencer cmd_sequencer_inst (
    .clk, .rst_n, .rx_byte, .rx_valid, .reply_byte, .reply_valid, .reply_ready,
    .mem_req, .mem_rdata, .bus_addr, .bus_data, .conf, .trs_io_access,
    .dbus_latch, .int_req, .led
  );

  trs_bus_port trs_bus_port_inst (
    .clk, .rst_n, .a, .d_in, .rd_n, .wr_n, .in_n, .out_n, .ioreq_n, .conf,
    .sel, .access_edge, .trs_io_access, .bus_addr, .bus_data,
    .host_rdata, .dbus_latch, .d_out, .d_oe
  );

  esp_wait_ctrl esp_wait_ctrl_inst (
    .clk, .rst_n, .sel, .access_edge, .done, .req, .wait_req, .esp_s
  );

  shared_ram shared_ram_inst (
    .clk,
    .sel,
    .access_edge,
    .a_addr     (a[RAM_AW-1:0]),
    .d_in,
    .host_rdata,
    .mem_req,
    .mem_rdata
  );

endmodule

`default_nettype wire

/* test/trs_io_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module trs_io_asserts
  import trs_io_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       reply_valid,
  input logic       reply_ready,
  input logic [7:0] reply_byte,
  input logic       rx_valid,
  input logic       access_edge,
  input trs_sel_t   sel,
  input logic       done,
  input logic       wait_req,
  input logic       int_req
);

  int   hold_fails    = 0;
  int   wait_fails    = 0;
  int   release_fails = 0;
  int   int_fails     = 0;
  int   fail_total;
  logic esp_access;

  assign esp_access = sel.esp_in | sel.esp_out;
  assign fail_total = hold_fails + wait_fails + release_fails + int_fails;

  // reply held until the link takes it
  reply_hold: assert property (@(posedge clk) disable iff (!rst_n)
    reply_valid && !reply_ready |=> reply_valid && $stable(reply_byte))
    else begin
      $error("reply byte changed or dropped before the handshake");
      hold_fails++;
    end

  wait_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wait_req) |-> $past(access_edge && esp_access))
    else begin
      $error("wait_req rose without an access edge on a serviced port");
      wait_fails++;
    end

  // done passes two sync flops and an edge detect before wait drops
  wait_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(wait_req) |-> $past(done, 3))
    else begin
      $error("wait_req fell without done from the microcontroller");
      release_fails++;
    end

  int_clear: assert property (@(posedge clk) disable iff (!rst_n)
    access_edge && sel.trs_io_hit && !rx_valid |=> !int_req)
    else begin
      $error("int_req still high after a host access to port 1fh");
      int_fails++;
    end

endmodule

bind trs_io_top trs_io_asserts trs_io_asserts_inst (
  .clk         (clk),
  .rst_n       (rst_n),
  .reply_valid (reply_valid),
  .reply_ready (reply_ready),
  .reply_byte  (reply_byte),
  .rx_valid    (rx_valid),
  .access_edge (access_edge),
  .sel         (sel),
  .done        (done),
  .wait_req    (wait_req),
  .int_req     (int_req)
);

`default_nettype wire

/* test/tb_trs_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_trs_io
  import trs_io_pkg::*;
();

  localparam int SCK_HALF      = 8;   // clk cycles per sck half period
  localparam int REPLY_TIMEOUT = 64;
  localparam int BUS_TIMEOUT   = 32;
  localparam int REQ_TIMEOUT   = 100; // req pulse is 50 cycles

  logic        clk = 1'b0;
  logic        rst_n;
  logic [15:0] a;
  logic [7:0]  d_in;
  logic [7:0]  d_out;
  logic        d_oe;
  logic        rd_n, wr_n, in_n, out_n, ioreq_n;
  logic [3:0]  conf;
  logic        sck, cs_n, mosi, miso;
  logic        req, done, wait_req, int_req;
  esp_code_e   esp_s;
  logic [2:0]  led;

  logic [31:0] rng_state;
  logic [7:0]  latch_value; // last byte sent with dbus_write
  int          check_count;
  int          error_count;
  int          timeout_count;

  trs_io_top trs_io_top_inst (.*);

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] rand_byte();
    rng_state = xorshift32(rng_state);
    return rng_state[7:0];
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0d ns: %s is %02h, expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic check_code(input string name, input esp_code_e got, input esp_code_e exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0d ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("timed out waiting for %s", what);
  endtask

  // shifts one spi mode 0 byte msb first and samples miso just before each rise
  task automatic spi_exchange(input logic [7:0] tx, input logic wait_reply,
                              output logic [7:0] rx);
    int   i;
    int   n;
    logic seen;
    rx = 8'h00;
    for (i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (SCK_HALF) step();
      rx[i] = miso;
      sck = 1'b1;
      if (wait_reply && i == 0) begin // reply must load before the last fall
        seen = 1'b0;
        n = 0;
        while (!seen && n < REPLY_TIMEOUT) begin
          @(negedge clk);
          seen = trs_io_top_inst.reply_valid & trs_io_top_inst.reply_ready;
          n++;
        end
        if (!seen)
          report_timeout("the spi reply handshake");
      end
      repeat (SCK_HALF) step();
      sck = 1'b0;
    end
  endtask

  // opcode, params, then one dummy byte that carries the reply back
  task automatic spi_command(input cmd_op_e op, input int nparams, input logic [7:0] p0,
                             input logic [7:0] p1, input logic [7:0] p2,
                             input logic want_reply, output logic [7:0] reply);
    logic [7:0] frame [0:3];
    logic [7:0] ignored;
    int         i;
    frame[0] = op;
    frame[1] = p0;
    frame[2] = p1;
    frame[3] = p2;
    reply = 8'h00;
    cs_n = 1'b0;
    repeat (SCK_HALF) step();
    for (i = 0; i <= nparams; i++)
      spi_exchange(frame[i], want_reply && i == nparams, ignored);
    if (want_reply)
      spi_exchange(rand_byte(), 1'b0, reply);
    repeat (SCK_HALF) step();
    cs_n = 1'b1;
    repeat (SCK_HALF) step();
  endtask

  task automatic host_mem_read(input logic [15:0] addr, output logic [7:0] data);
    int   n;
    logic seen;
    a = addr;
    rd_n = 1'b0;
    seen = 1'b0;
    n = 0;
    while (!seen && n < BUS_TIMEOUT) begin
      @(negedge clk);
      seen = trs_io_top_inst.access_edge;
      n++;
    end
    if (!seen)
      report_timeout("the access edge of a ram read");
    repeat (2) @(posedge clk); // data valid 2 cycles after the edge
    @(negedge clk);
    check_bit("d_oe", d_oe, 1'b1);
    data = d_out;
    step();
    rd_n = 1'b1;
    repeat (4) step();
  endtask

  task automatic host_mem_write(input logic [15:0] addr, input logic [7:0] data);
    int   n;
    logic seen;
    a = addr;
    d_in = data;
    wr_n = 1'b0;
    seen = 1'b0;
    n = 0;
    while (!seen && n < BUS_TIMEOUT) begin
      @(negedge clk);
      seen = trs_io_top_inst.access_edge;
      n++;
    end
    if (!seen)
      report_timeout("the access edge of a ram write");
    step();
    wr_n = 1'b1;
    repeat (4) step();
  endtask

  // exp_code none means the port is not serviced and must not stall the host
  task automatic host_io_access(input logic [7:0] port, input logic is_in,
                                input logic [7:0] wdata, input esp_code_e exp_code,
                                input logic [7:0] exp_rdata);
    int n;
    a = {rand_byte(), port};
    d_in = wdata;
    ioreq_n = 1'b0;
    in_n = ~is_in;
    out_n = is_in;
    if (exp_code != none) begin
      n = 0;
      @(negedge clk);
      while (!wait_req && n < BUS_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!wait_req)
        report_timeout("wait_req on a serviced port");
      check_code("esp_s", esp_s, exp_code);
      check_bit("req", req, 1'b1);
      if (is_in) begin
        check_bit("d_oe", d_oe, 1'b1);
        check_byte("d_out", d_out, exp_rdata);
      end
      step();
      done = 1'b1;
      repeat (2) step();
      done = 1'b0;
      n = 0;
      while (wait_req && n < BUS_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (wait_req)
        report_timeout("wait_req to fall after done");
    end else begin
      for (n = 0; n < 12; n++) begin
        @(negedge clk);
        check_bit("req", req, 1'b0);
        check_bit("wait_req", wait_req, 1'b0);
      end
      check_code("esp_s", esp_s, none);
    end
    step();
    in_n = 1'b1;
    out_n = 1'b1;
    ioreq_n = 1'b1;
    n = 0;
    while (req && n < REQ_TIMEOUT) begin
      step();
      n++;
    end
    if (req)
      report_timeout("the req pulse to end");
    repeat (4) step();
  endtask

  task automatic ident_replies();
    logic [7:0] r;
    spi_command(get_cookie, 0, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_byte("get_cookie reply", r, 8'haf);
    spi_command(get_version, 0, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_byte("get_version reply", r, 8'h03);
    spi_command(get_config, 0, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_byte("get_config reply", r, {4'h0, conf});
  endtask

  task automatic ram_both_ports();
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] data;
    logic [7:0] r;
    lo = rand_byte();
    hi = rand_byte();
    data = rand_byte();
    spi_command(bram_poke, 3, lo, {1'b0, hi[6:0]}, data, 1'b0, r);
    host_mem_read({1'b1, hi[6:0], lo}, r);
    check_byte("host ram read", r, data);
    lo = rand_byte();
    hi = rand_byte();
    data = rand_byte();
    host_mem_write({1'b1, hi[6:0], lo}, data);
    spi_command(bram_peek, 2, lo, {1'b0, hi[6:0]}, 8'h00, 1'b1, r);
    check_byte("bram_peek reply", r, data);
  endtask

  task automatic trs_io_port_read();
    logic [7:0] r;
    latch_value = rand_byte();
    spi_command(dbus_write, 1, latch_value, 8'h00, 8'h00, 1'b0, r);
    host_io_access(8'h1f, 1'b1, 8'h00, trs_io_in, latch_value);
  endtask

  task automatic port_decode();
    host_io_access(8'hc5, 1'b0, rand_byte(), frehd_out, 8'h00);
    host_io_access(8'h20, 1'b1, 8'h00, none, 8'h00);
    host_io_access(8'h20, 1'b0, rand_byte(), none, 8'h00);
  endtask

  task automatic model3_int_and_led();
    logic [7:0] r;
    logic [7:0] p;
    int         n;
    spi_command(data_ready, 0, 8'h00, 8'h00, 8'h00, 1'b0, r);
    check_bit("int_req", int_req, 1'b0); // flag set, still model i
    conf = 4'h2; // conf[3] low
    n = 0;
    while (!int_req && n < BUS_TIMEOUT) begin
      step();
      n++;
    end
    if (!int_req)
      report_timeout("int_req after data_ready");
    host_io_access(8'h1f, 1'b1, 8'h00, trs_io_in, latch_value);
    check_bit("int_req", int_req, 1'b0);
    p = rand_byte();
    spi_command(set_led, 1, p, 8'h00, 8'h00, 1'b0, r);
    check_byte("led", {5'd0, led}, {5'd0, p[2:0]});
    conf = 4'ha;
    repeat (4) step();
  endtask

  task automatic bus_readback();
    logic [7:0] r;
    a = {rand_byte(), rand_byte()};
    d_in = rand_byte();
    spi_command(abus_read, 0, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_byte("abus_read reply", r, a[7:0]);
    spi_command(dbus_read, 0, 8'h00, 8'h00, 8'h00, 1'b1, r);
    check_byte("dbus_read reply", r, d_in);
  endtask

  initial begin
    int assert_fails;
    rng_state = 32'haf20;
    latch_value = 8'h00;
    check_count = 0;
    error_count = 0;
    timeout_count = 0;
    rst_n = 1'b0;
    a = 16'h0000;
    d_in = 8'h00;
    rd_n = 1'b1;
    wr_n = 1'b1;
    in_n = 1'b1;
    out_n = 1'b1;
    ioreq_n = 1'b1;
    conf = 4'ha; // model i
    sck = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    done = 1'b0;
    repeat (10) step();
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("req", req, 1'b0);
    check_bit("wait_req", wait_req, 1'b0);
    check_bit("int_req", int_req, 1'b0);
    check_bit("d_oe", d_oe, 1'b0);
    check_byte("led", {5'd0, led}, 8'h00);
    check_code("esp_s", esp_s, none);
    step();
    ident_replies();
    ram_both_ports();
    trs_io_port_read();
    port_decode();
    model3_int_and_led();
    bus_readback();
    assert_fails = trs_io_top_inst.trs_io_asserts_inst.fail_total;
    $display("checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
             check_count, error_count, timeout_count, assert_fails);
    if (error_count == 0 && timeout_count == 0 && assert_fails == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
source/trs_io_pkg.sv
source/spi_byte_link.sv
source/cmd_sequencer.sv
source/trs_bus_port.sv
source/esp_wait_ctrl.sv
source/shared_ram.sv
source/trs_io_top.sv
test/trs_io_asserts.sv
test/tb_trs_io.sv

/* Makefile */
TOP = tb_trs_io

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -Mdir obj_dir -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
